// ==== logic/therm_cfg.svh ====
// Thermometer controller configuration
`ifndef THERM_CFG_SVH
`define THERM_CFG_SVH

// ==================================================
// Serial timing
// ==================================================

// Clk cycles per half period of the serial clock, 2 or more
`define THERM_HALF_DIV 4

// Clk cycles of chip enable before the first falling serial clock
`define THERM_CE_SETUP 4

// ==================================================
// Data widths
// ==================================================

// Bus and sensor data word
`define THERM_DATA_W 16

`endif

// ==== logic/therm_bus_pkg.sv ====
// Processor bus types
`default_nettype none

`include "therm_cfg.svh"

package therm_bus_pkg;

	// Register map, two address bits only
	typedef enum logic [1:0]
	{
		REG_CMD    = 2'd0,
		REG_DATA   = 2'd1,
		REG_STATUS = 2'd2,
		REG_RSVD   = 2'd3
	} reg_addr_e;

	// Request from the processor
	// Strobe is one cycle, no back-pressure
	typedef struct packed
	{
		logic                     stb;
		logic                     we;
		reg_addr_e                addr;
		logic [`THERM_DATA_W-1:0] wdata;
	} bus_req_t;

	// Response, always one cycle after the strobe
	typedef struct packed
	{
		logic                     ack;
		logic [`THERM_DATA_W-1:0] rdata;
	} bus_rsp_t;

endpackage

`default_nettype wire

// ==== logic/therm_cmd_pkg.sv ====
// Sensor command and data types
`default_nettype none

`include "therm_cfg.svh"

package therm_cmd_pkg;

	// Sensor opcodes
	typedef enum logic [7:0]
	{
		START_CNV    = 8'h51,
		STOP_CNV     = 8'h22,
		READ_TEMP    = 8'hAA,
		READ_CONFIG  = 8'hAC,
		READ_TH      = 8'hA1,
		READ_TL      = 8'hA2,
		WRITE_TH     = 8'h01,
		WRITE_TL     = 8'h02,
		WRITE_CONFIG = 8'h0C,
		POR          = 8'h54
	} therm_op_e;

	// Temperature view, 12 bit two's complement left aligned
	typedef struct packed
	{
		logic signed [11:0] value;
		logic [3:0]         zero;
	} temp_view_t;

	// Configuration view, status flags and mode in the low byte
	typedef struct packed
	{
		logic [7:0] unused;
		logic       done;
		logic       thf;
		logic       tlf;
		logic       nvb;
		logic [3:0] mode;
	} cfg_view_t;

	// One sensor word, decoded per opcode
	typedef union packed
	{
		temp_view_t               temp;
		cfg_view_t                cfg;
		logic [`THERM_DATA_W-1:0] raw;
	} therm_data_u;

	// ==================================================
	// Data phase rule
	// ==================================================

	// Bits in the data phase, zero for bare commands
	function automatic logic [3:0] op_data_len(therm_op_e op);
		case (op)
			READ_TEMP, READ_TH, READ_TL, WRITE_TH, WRITE_TL: return 4'd12;
			READ_CONFIG, WRITE_CONFIG: return 4'd8;
			default: return 4'd0;
		endcase
	endfunction

	// Read opcodes shift in, all others shift out
	function automatic logic op_is_read(therm_op_e op);
		return (op == READ_TEMP) || (op == READ_TH) || (op == READ_TL) ||
			(op == READ_CONFIG);
	endfunction

endpackage

`default_nettype wire

// ==== logic/therm_regs.sv ====
// Thermometer register block
`timescale 1ns/1ns
`default_nettype none

`include "therm_cfg.svh"

module therm_regs
(
	input  wire                          clk,
	input  wire                          rst,
	input  therm_bus_pkg::bus_req_t      req_i,
	output therm_bus_pkg::bus_rsp_t      rsp_o,
	output logic                         start_o,
	output therm_cmd_pkg::therm_op_e     op_o,
	output logic [`THERM_DATA_W-1:0]     wdata_o,
	input  wire                          busy_i,
	input  wire                          done_i,
	input  wire  [`THERM_DATA_W-1:0]     rdata_i
);

	import therm_bus_pkg::*;
	import therm_cmd_pkg::*;

	// Control state
	logic ack_q;
	logic start_q;
	logic overrun_q;
	logic cnv_done_q;

	// Payload
	therm_op_e                op_q;
	logic [`THERM_DATA_W-1:0] wdata_q;
	therm_data_u              result_q;
	therm_data_u              rx_view;
	logic [`THERM_DATA_W-1:0] rdata_q;
	logic [`THERM_DATA_W-1:0] rd_mux;

	// Decoded accesses
	logic cmd_wr;
	logic data_wr;
	logic stat_rd;
	logic busy_any;

	// ==================================================
	// Access decode
	// ==================================================

	assign cmd_wr  = req_i.stb && req_i.we && (req_i.addr == REG_CMD);
	assign data_wr = req_i.stb && req_i.we && (req_i.addr == REG_DATA);
	assign stat_rd = req_i.stb && !req_i.we && (req_i.addr == REG_STATUS);

	// Busy as the processor sees it, start counts before the engine answers
	assign busy_any = busy_i || start_q;

	// Received word seen through the union views
	assign rx_view.raw = rdata_i;

	// Read mux
	always_comb
	begin
		case (req_i.addr)
			REG_DATA: rd_mux = result_q.raw;
			REG_STATUS: rd_mux = {13'd0, overrun_q, cnv_done_q, busy_any};
			// CMD and the spare address read zero
			default: rd_mux = '0;
		endcase
	end

	// ==================================================
	// Control registers
	// ==================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ack_q      <= 1'b0;
			start_q    <= 1'b0;
			overrun_q  <= 1'b0;
			cnv_done_q <= 1'b0;
		end
		else
		begin
			ack_q   <= req_i.stb;
			// Launch only from idle
			start_q <= cmd_wr && !busy_any;
			// Command while busy is lost, STATUS read clears the flag
			if (cmd_wr && busy_any)
				overrun_q <= 1'b1;
			else if (stat_rd)
				overrun_q <= 1'b0;
			// Keep done from the last configuration read
			if (done_i && (op_q == READ_CONFIG))
				cnv_done_q <= rx_view.cfg.done;
		end
	end

	// Payload registers
	always_ff @(posedge clk)
	begin
		if (data_wr)
			wdata_q <= req_i.wdata;
		if (cmd_wr && !busy_any)
			op_q <= therm_op_e'(req_i.wdata[7:0]);
		if (done_i)
		begin
			// Temperature moves to the upper 12 bits
			if (op_q == READ_TEMP)
			begin
				result_q.temp.value <= rx_view.raw[11:0];
				result_q.temp.zero  <= '0;
			end
			else
				result_q.raw <= rx_view.raw;
		end
		rdata_q <= (req_i.stb && !req_i.we) ? rd_mux : '0;
	end

	assign rsp_o.ack   = ack_q;
	assign rsp_o.rdata = rdata_q;
	assign start_o     = start_q;
	assign op_o        = op_q;
	assign wdata_o     = wdata_q;

	// Engine is never restarted mid transaction
	a_start_idle: assert property (@(posedge clk) disable iff (rst) start_o |-> !busy_i);

endmodule

`default_nettype wire

// ==== logic/therm_serial.sv ====
// Three-wire serial engine
`timescale 1ns/1ns
`default_nettype none

`include "therm_cfg.svh"

module therm_serial
(
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          start_i,
	input  therm_cmd_pkg::therm_op_e     op_i,
	input  wire  [`THERM_DATA_W-1:0]     wdata_i,
	output logic                         busy_o,
	output logic                         done_o,
	output logic [`THERM_DATA_W-1:0]     rdata_o,
	output logic                         sensor_ce_o,
	output logic                         sclk_o,
	output logic                         dq_o,
	output logic                         dq_oe_o,
	input  wire                          dq_i
);

	import therm_cmd_pkg::*;

	// Counter covers both the half period and the setup delay
	localparam int CNT_MAX = (`THERM_HALF_DIV > `THERM_CE_SETUP) ?
		`THERM_HALF_DIV : `THERM_CE_SETUP;
	localparam int CNT_W = $clog2(CNT_MAX + 1);

	typedef enum logic [2:0]
	{
		ST_IDLE,
		ST_SETUP,
		ST_OPCODE,
		ST_DATA,
		ST_FINISH
	} state_e;

	state_e state_q;

	// Timing
	logic [CNT_W-1:0] half_q;
	logic [3:0]       bit_q;
	logic [3:0]       nxt_bit;

	// Pin registers
	logic ce_q;
	logic sclk_q;
	logic dq_q;
	logic oe_q;

	// Transaction payload
	logic [7:0]               op_bits;
	logic [3:0]               len_q;
	logic                     rd_q;
	logic [`THERM_DATA_W-1:0] tx_q;
	therm_data_u              rx_q;

	assign nxt_bit = bit_q + 4'd1;

	// ==================================================
	// Sequencer
	// ==================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q <= ST_IDLE;
			half_q  <= '0;
			bit_q   <= '0;
			ce_q    <= 1'b0;
			sclk_q  <= 1'b1;
			dq_q    <= 1'b0;
			oe_q    <= 1'b0;
		end
		else
		begin
			case (state_q)
				ST_IDLE:
				begin
					if (start_i)
					begin
						ce_q    <= 1'b1;
						half_q  <= CNT_W'(`THERM_CE_SETUP - 1);
						state_q <= ST_SETUP;
					end
				end
				ST_SETUP:
				begin
					if (half_q == '0)
					begin
						// First fall, opcode bit 0 goes out
						sclk_q  <= 1'b0;
						dq_q    <= op_bits[0];
						oe_q    <= 1'b1;
						bit_q   <= '0;
						half_q  <= CNT_W'(`THERM_HALF_DIV - 1);
						state_q <= ST_OPCODE;
					end
					else
						half_q <= half_q - 1'b1;
				end
				ST_OPCODE, ST_DATA:
				begin
					if (half_q != '0)
						half_q <= half_q - 1'b1;
					else
					begin
						half_q <= CNT_W'(`THERM_HALF_DIV - 1);
						if (!sclk_q)
							// Rising edge, sensor samples here too
							sclk_q <= 1'b1;
						else if (state_q == ST_OPCODE && bit_q != 4'd7)
						begin
							sclk_q <= 1'b0;
							bit_q  <= nxt_bit;
							dq_q   <= op_bits[nxt_bit[2:0]];
						end
						else if (state_q == ST_OPCODE && len_q != '0)
						begin
							// Into the data phase, release the line for reads
							sclk_q  <= 1'b0;
							bit_q   <= '0;
							state_q <= ST_DATA;
							oe_q    <= !rd_q;
							dq_q    <= tx_q[0];
						end
						else if (state_q == ST_DATA && nxt_bit != len_q)
						begin
							sclk_q <= 1'b0;
							bit_q  <= nxt_bit;
							dq_q   <= tx_q[nxt_bit];
						end
						else
						begin
							// Last bit done, clock stays high
							ce_q    <= 1'b0;
							oe_q    <= 1'b0;
							state_q <= ST_FINISH;
						end
					end
				end
				ST_FINISH:
					state_q <= ST_IDLE;
				default:
					state_q <= ST_IDLE;
			endcase
		end
	end

	// Transaction payload, latched at start
	always_ff @(posedge clk)
	begin
		if (state_q == ST_IDLE && start_i)
		begin
			op_bits <= op_i;
			len_q   <= op_data_len(op_i);
			rd_q    <= op_is_read(op_i);
			tx_q    <= wdata_i;
			rx_q    <= '0;
		end
		else if (state_q == ST_DATA && rd_q && half_q == '0 && !sclk_q)
			// Sample on the rising serial clock, LSB first
			rx_q.raw[bit_q] <= dq_i;
	end

	assign busy_o      = (state_q != ST_IDLE);
	assign done_o      = (state_q == ST_FINISH);
	assign rdata_o     = rx_q.raw;
	assign sensor_ce_o = ce_q;
	assign sclk_o      = sclk_q;
	assign dq_o        = dq_q;
	assign dq_oe_o     = oe_q;

	// No drive against the sensor while it talks
	a_read_release: assert property (@(posedge clk) disable iff (rst)
		(state_q == ST_DATA && rd_q) |-> !dq_oe_o);

	// Clock parks high outside a transaction
	a_sclk_idle: assert property (@(posedge clk) disable iff (rst)
		!sensor_ce_o |-> sclk_o);

endmodule

`default_nettype wire

// ==== logic/therm_top.sv ====
// Thermometer controller top level
`timescale 1ns/1ns
`default_nettype none

`include "therm_cfg.svh"

module therm_top
(
	input  wire                          clk,
	input  wire                          rst,
	input  therm_bus_pkg::bus_req_t      bus_req_i,
	output therm_bus_pkg::bus_rsp_t      bus_rsp_o,
	output logic                         sensor_ce_o,
	output logic                         sclk_o,
	output logic                         dq_o,
	output logic                         dq_oe_o,
	input  wire                          dq_i
);

	import therm_cmd_pkg::*;

	// Register block to engine
	logic                     start;
	therm_op_e                op;
	logic [`THERM_DATA_W-1:0] wdata;

	// Engine back to register block
	logic                     busy;
	logic                     done;
	logic [`THERM_DATA_W-1:0] rdata;

	// Bus side, decode and result holding
	therm_regs u_regs
	(
		.clk     (clk),
		.rst     (rst),
		.req_i   (bus_req_i),
		.rsp_o   (bus_rsp_o),
		.start_o (start),
		.op_o    (op),
		.wdata_o (wdata),
		.busy_i  (busy),
		.done_i  (done),
		.rdata_i (rdata)
	);

	// Sensor side, three-wire sequencing
	therm_serial u_serial
	(
		.clk         (clk),
		.rst         (rst),
		.start_i     (start),
		.op_i        (op),
		.wdata_i     (wdata),
		.busy_o      (busy),
		.done_o      (done),
		.rdata_o     (rdata),
		.sensor_ce_o (sensor_ce_o),
		.sclk_o      (sclk_o),
		.dq_o        (dq_o),
		.dq_oe_o     (dq_oe_o),
		.dq_i        (dq_i)
	);

endmodule

`default_nettype wire

// ==== test/therm_sensor_model.sv ====
// Behavioral three-wire thermometer
`timescale 1ns/1ns
`default_nettype none

module therm_sensor_model
(
	input  wire        ce_i,
	input  wire        sclk_i,
	input  wire        dq_i,
	input  wire        dq_oe_i,
	output logic       dq_o,
	input  wire [11:0] load_temp_i
);

	import therm_cmd_pkg::*;

	// Sensor registers
	logic [11:0] th_q   = '0;
	logic [11:0] tl_q   = '0;
	logic [11:0] temp_q = '0;
	logic [7:0]  cfg_q  = '0;

	// Transaction state
	logic        ce_last   = 1'b0;
	logic        sclk_last = 1'b1;
	logic [7:0]  op_q      = '0;
	logic [11:0] shift_q   = '0;
	logic [11:0] tx_q      = '0;
	int          bit_cnt   = 0;
	int          data_len  = 0;
	logic        rd_phase  = 1'b0;
	logic        dq_q      = 1'b1;
	logic        line;

	// Undriven line floats high
	assign line = dq_oe_i ? dq_i : 1'b1;
	assign dq_o = dq_q;

	// Opcode known after the eighth bit
	task automatic decode_op();
		rd_phase = 1'b0;
		data_len = 0;
		case (op_q)
			START_CNV:
			begin
				// Conversion result latched here
				temp_q   = load_temp_i;
				cfg_q[7] = 1'b1;
			end
			STOP_CNV: cfg_q[7] = 1'b0;
			POR: cfg_q = '0;
			READ_TEMP:
			begin
				rd_phase = 1'b1;
				data_len = 12;
				tx_q     = temp_q;
			end
			READ_TH:
			begin
				rd_phase = 1'b1;
				data_len = 12;
				tx_q     = th_q;
			end
			READ_TL:
			begin
				rd_phase = 1'b1;
				data_len = 12;
				tx_q     = tl_q;
			end
			READ_CONFIG:
			begin
				rd_phase = 1'b1;
				data_len = 8;
				tx_q     = {4'h0, cfg_q};
			end
			WRITE_TH, WRITE_TL: data_len = 12;
			WRITE_CONFIG: data_len = 8;
			default: data_len = 0;
		endcase
	endtask

	// Write lands when chip enable drops
	task automatic commit_write();
		case (op_q)
			WRITE_TH: th_q = shift_q;
			WRITE_TL: tl_q = shift_q;
			WRITE_CONFIG: cfg_q = shift_q[7:0];
			default: ;
		endcase
	endtask

	// ==================================================
	// Pin activity
	// ==================================================

	always @(posedge ce_i or negedge ce_i or posedge sclk_i or negedge sclk_i)
	begin
		if (ce_i && !ce_last)
		begin
			bit_cnt  = 0;
			data_len = 0;
			rd_phase = 1'b0;
			op_q     = '0;
			shift_q  = '0;
		end
		else if (!ce_i && ce_last)
		begin
			dq_q = 1'b1;
			if (!rd_phase && data_len != 0 && bit_cnt == 8 + data_len)
				commit_write();
		end
		else if (ce_i && sclk_i && !sclk_last)
		begin
			// Rising clock, opcode then write data, LSB first
			if (bit_cnt < 8)
			begin
				op_q[bit_cnt] = line;
				if (bit_cnt == 7)
					decode_op();
			end
			else if (!rd_phase && bit_cnt - 8 < data_len)
				shift_q[bit_cnt - 8] = line;
			bit_cnt++;
		end
		else if (ce_i && !sclk_i && sclk_last && rd_phase && bit_cnt >= 8 &&
			bit_cnt - 8 < data_len)
			dq_q = tx_q[bit_cnt - 8];  // next read bit after the fall
		ce_last   = ce_i;
		sclk_last = sclk_i;
	end

endmodule

`default_nettype wire

// ==== test/therm_checker.sv ====
// Bus response checker
`timescale 1ns/1ns
`default_nettype none

module therm_checker
(
	input  wire                     clk,
	input  wire                     rst,
	input  therm_bus_pkg::bus_req_t req_i,
	input  therm_bus_pkg::bus_rsp_t rsp_i,
	output int                      err_count_o,
	output int                      check_count_o
);

	import therm_bus_pkg::*;
	import therm_cmd_pkg::*;

	// Request seen at the previous falling edge
	bus_req_t last_req;

	// Shadow of the sensor and of the register block
	logic [11:0] th_s;
	logic [11:0] tl_s;
	logic [11:0] temp_s;
	logic [7:0]  cfg_s;
	logic [15:0] wdata_s;
	logic [15:0] data_s;
	logic        data_known;
	logic        in_flight;
	logic        busy_due;
	logic        overrun_s;
	logic        done_s;
	therm_op_e   pend_op;
	logic [15:0] pend_wdata;

	task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
		check_count_o++;
		if (act !== exp)
		begin
			err_count_o++;
			$display("** Error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	// Effect of a finished transaction
	task automatic finish_op();
		therm_data_u word;
		word.raw   = '0;
		in_flight  = 1'b0;
		data_known = 1'b1;
		case (pend_op)
			WRITE_TH: th_s = pend_wdata[11:0];
			WRITE_TL: tl_s = pend_wdata[11:0];
			WRITE_CONFIG: cfg_s = pend_wdata[7:0];
			START_CNV: cfg_s[7] = 1'b1;
			STOP_CNV: cfg_s[7] = 1'b0;
			POR: cfg_s = '0;
			READ_TH: word.raw = {4'h0, th_s};
			READ_TL: word.raw = {4'h0, tl_s};
			// Temperature in the upper 12 bits, low nibble zero
			READ_TEMP: word.raw = {temp_s, 4'h0};
			READ_CONFIG:
			begin
				word.raw = {8'h00, cfg_s};
				// Done is the top bit of the configuration byte
				done_s   = cfg_s[7];
			end
			default: ;
		endcase
		data_s = word.raw;
	endtask

	// ==================================================
	// Completed accesses
	// ==================================================

	task automatic observe_write(input bus_req_t req);
		case (req.addr)
			REG_DATA: wdata_s = req.wdata;
			REG_CMD:
			begin
				if (in_flight)
					overrun_s = 1'b1;
				else
				begin
					in_flight  = 1'b1;
					busy_due   = 1'b1;
					pend_op    = therm_op_e'(req.wdata[7:0]);
					pend_wdata = wdata_s;
					// Temperature the model will latch
					if (pend_op == START_CNV)
						temp_s = therm_tb.u_sensor.load_temp_i;
				end
			end
			default: ;
		endcase
	endtask

	task automatic check_read(input reg_addr_e addr, input logic [15:0] rdata);
		case (addr)
			REG_DATA:
				if (data_known)
					compare("rdata DATA", data_s, rdata);
			REG_STATUS:
			begin
				// Busy falling ends the transaction
				if (in_flight && !rdata[0])
					finish_op();
				if (busy_due)
					compare("rdata STATUS.busy", 16'd1, {15'd0, rdata[0]});
				compare("rdata STATUS.done", {15'd0, done_s}, {15'd0, rdata[1]});
				compare("rdata STATUS.overrun", {15'd0, overrun_s}, {15'd0, rdata[2]});
				compare("rdata STATUS spare", 16'd0, {3'd0, rdata[15:3]});
				overrun_s = 1'b0;
				busy_due  = 1'b0;
			end
			REG_RSVD: compare("rdata RSVD", 16'd0, rdata);
			default: compare("rdata CMD", 16'd0, rdata);
		endcase
	endtask

	// Sampled mid cycle where every output is settled
	always @(negedge clk)
	begin
		if (rst)
		begin
			last_req      = '0;
			th_s          = '0;
			tl_s          = '0;
			temp_s        = '0;
			cfg_s         = '0;
			wdata_s       = '0;
			data_s        = '0;
			data_known    = 1'b0;
			in_flight     = 1'b0;
			busy_due      = 1'b0;
			overrun_s     = 1'b0;
			done_s        = 1'b0;
			pend_op       = POR;
			pend_wdata    = '0;
			err_count_o   = 0;
			check_count_o = 0;
		end
		else
		begin
			// Acknowledge exactly one cycle after each strobe
			compare("rsp.ack", {15'd0, last_req.stb}, {15'd0, rsp_i.ack});
			if (last_req.stb && last_req.we)
				observe_write(last_req);
			else if (last_req.stb)
				check_read(last_req.addr, rsp_i.rdata);
			last_req = req_i;
		end
	end

endmodule

`default_nettype wire

// ==== test/therm_tb.sv ====
// Thermometer controller testbench
`timescale 1ns/1ns
`default_nettype none

`include "therm_cfg.svh"

module therm_tb;

	import therm_bus_pkg::*;
	import therm_cmd_pkg::*;

	// One table row
	typedef struct packed
	{
		therm_op_e   op;
		logic [15:0] wdata;
		logic        rd_follow;
		logic        collide;
	} row_t;

	localparam int N_ROWS = 18;
	localparam int WATCHDOG_CYCLES = N_ROWS *
		(`THERM_CE_SETUP + 20 * 2 * `THERM_HALF_DIV + 40) * 2;

	logic        clk;
	logic        rst;
	bus_req_t    bus_req;
	bus_rsp_t    bus_rsp;
	logic        sensor_ce;
	logic        sclk;
	logic        dq_out;
	logic        dq_oe;
	logic        dq_in;
	logic [11:0] temp_load;
	int          cnv_count;
	int          err_count;
	int          check_count;
	row_t        rows [N_ROWS];

	therm_top UUT
	(
		.clk         (clk),
		.rst         (rst),
		.bus_req_i   (bus_req),
		.bus_rsp_o   (bus_rsp),
		.sensor_ce_o (sensor_ce),
		.sclk_o      (sclk),
		.dq_o        (dq_out),
		.dq_oe_o     (dq_oe),
		.dq_i        (dq_in)
	);

	therm_sensor_model u_sensor
	(
		.ce_i        (sensor_ce),
		.sclk_i      (sclk),
		.dq_i        (dq_out),
		.dq_oe_i     (dq_oe),
		.dq_o        (dq_in),
		.load_temp_i (temp_load)
	);

	therm_checker u_checker
	(
		.clk           (clk),
		.rst           (rst),
		.req_i         (bus_req),
		.rsp_i         (bus_rsp),
		.err_count_o   (err_count),
		.check_count_o (check_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ==================================================
	// Bus access
	// ==================================================

	// Strobe for one cycle, response sampled after the acknowledge edge
	task automatic bus_cycle(input logic we, input reg_addr_e addr, input logic [15:0] wdata,
		output logic [15:0] rdata);
		@(posedge clk);
		#1;
		bus_req.stb   = 1'b1;
		bus_req.we    = we;
		bus_req.addr  = addr;
		bus_req.wdata = wdata;
		@(posedge clk);
		#1;
		bus_req = '0;
		rdata   = bus_rsp.rdata;
	endtask

	task automatic bus_write(input reg_addr_e addr, input logic [15:0] wdata);
		logic [15:0] unused;
		bus_cycle(1'b1, addr, wdata, unused);
	endtask

	task automatic bus_read(input reg_addr_e addr, output logic [15:0] rdata);
		bus_cycle(1'b0, addr, 16'h0000, rdata);
	endtask

	task automatic load_temperature();
		logic [11:0] t;
		t = 12'($urandom());
		// Sign alternates between conversions
		t[11]     = cnv_count[0];
		temp_load = t;
		cnv_count++;
	endtask

	function automatic row_t mk_row(input therm_op_e op, input logic [15:0] wdata,
		input logic rd_follow, input logic collide);
		row_t r;
		r.op        = op;
		r.wdata     = wdata;
		r.rd_follow = rd_follow;
		r.collide   = collide;
		return r;
	endfunction

	// Launch, poll until idle, then fetch the result
	task automatic run_row(input row_t row);
		logic [15:0] st;
		logic [15:0] rd;
		if (row.op == WRITE_TH || row.op == WRITE_TL || row.op == WRITE_CONFIG)
			bus_write(REG_DATA, row.wdata);
		if (row.op == START_CNV)
			load_temperature();
		bus_write(REG_CMD, {8'h00, row.op});
		// Extra command while busy, dropped by the DUT
		if (row.collide)
			bus_write(REG_CMD, {8'h00, POR});
		bus_read(REG_STATUS, st);
		while (st[0])
			bus_read(REG_STATUS, st);
		if (row.rd_follow)
			bus_read(REG_DATA, rd);
	endtask

	// ==================================================
	// Stimulus table
	// ==================================================

	task automatic load_table();
		rows[0]  = mk_row(WRITE_TH, 16'hF19A, 1'b0, 1'b0);
		rows[1]  = mk_row(READ_TH, 16'h0000, 1'b1, 1'b0);
		rows[2]  = mk_row(WRITE_TL, 16'h3E65, 1'b0, 1'b0);
		rows[3]  = mk_row(READ_TL, 16'h0000, 1'b1, 1'b0);
		rows[4]  = mk_row(WRITE_CONFIG, 16'hA54F, 1'b0, 1'b0);
		rows[5]  = mk_row(READ_CONFIG, 16'h0000, 1'b1, 1'b0);
		rows[6]  = mk_row(START_CNV, 16'h0000, 1'b0, 1'b0);
		rows[7]  = mk_row(READ_CONFIG, 16'h0000, 1'b1, 1'b0);
		rows[8]  = mk_row(READ_TEMP, 16'h0000, 1'b1, 1'b0);
		rows[9]  = mk_row(START_CNV, 16'h0000, 1'b0, 1'b0);
		rows[10] = mk_row(READ_TEMP, 16'h0000, 1'b1, 1'b1);
		rows[11] = mk_row(STOP_CNV, 16'h0000, 1'b0, 1'b0);
		rows[12] = mk_row(READ_CONFIG, 16'h0000, 1'b1, 1'b0);
		rows[13] = mk_row(POR, 16'h0000, 1'b0, 1'b0);
		rows[14] = mk_row(READ_CONFIG, 16'h0000, 1'b1, 1'b0);
		rows[15] = mk_row(READ_TH, 16'h0000, 1'b1, 1'b0);
		rows[16] = mk_row(START_CNV, 16'h0000, 1'b0, 1'b0);
		rows[17] = mk_row(READ_TEMP, 16'h0000, 1'b1, 1'b1);
	endtask

	initial
	begin
		logic [15:0] rd;
		void'($urandom(1704));
		rst       = 1'b1;
		bus_req   = '0;
		temp_load = '0;
		cnv_count = 0;
		load_table();
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		// Spare and command addresses read zero
		bus_read(REG_RSVD, rd);
		bus_read(REG_CMD, rd);
		bus_read(REG_STATUS, rd);
		for (int i = 0; i < N_ROWS; i++)
			run_row(rows[i]);
		repeat (4) @(posedge clk);
		$display("Checks: %0d  Errors: %0d", check_count, err_count);
		if (err_count == 0 && check_count > 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Watchdog sized from the table length
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== therm_top.f ====
+incdir+logic
logic/therm_bus_pkg.sv
logic/therm_cmd_pkg.sv
logic/therm_regs.sv
logic/therm_serial.sv
logic/therm_top.sv
test/therm_sensor_model.sv
test/therm_checker.sv
test/therm_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the thermometer controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module therm_tb -f therm_top.f -o therm_sim \
	&& ./obj_dir/therm_sim > sim.log 2>&1 \
	|| echo "Build or simulation returned an error"

cat sim.log 2>/dev/null

grep -q "Result: PASSED" sim.log 2>/dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
